// ==== apb_periph.f ====
+incdir+include
design/apb_periph_pkg.sv
design/apb_periph_decode.sv
design/gpio_ctrl.sv
design/pwm_regs.sv
design/pwm_gen.sv
design/soc_ctrl_regs.sv
design/apb_periph_top.sv
verif/apb_periph_checker.sv
verif/tb_apb_periph.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_apb_periph
FILELIST = apb_periph.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== verif/tb_apb_periph.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the APB peripheral subsystem with APB
// stimulus, a shadow register model and the checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module tb_apb_periph
   import apb_periph_pkg::*;
;

   localparam int unsigned N_RAND_WR = 30;
   localparam int unsigned N_PWM_CFG = 3;

   logic                   clk = 1'b0;
   logic                   rst;
   apb_req_t               req;
   apb_rsp_t               apb_rsp;
   logic [`NUM_GPIO-1:0]   gpio_in;
   logic [`NUM_GPIO-1:0]   gpio_out;
   logic [`NUM_GPIO-1:0]   gpio_oe;
   logic [`PWM_CH-1:0]     pwm;
   cluster_ctrl_t          cluster;
   logic [31:0]            gwt_in;
   logic                   gwt_ie;
   logic [31:0]            gwt_out;
   logic                   chk_on = 1'b0;
   logic                   in_access = 1'b0;
   logic                   exp_err = 1'b0;
   logic [31:0]            exp_rdata = '0;
   logic [31:0]            rng_state = 32'd43772;

   // Shadow register model
   logic [31:0]            m_dir = '0;
   logic [31:0]            m_out = '0;
   logic [31:0]            m_in = '0;
   logic                   m_en = 1'b0;
   logic [15:0]            m_period = '0;
   logic [3:0][15:0]       m_duty = '0;
   logic [2:0]             m_cluster = '0;
   logic [31:0]            m_gwt = '0;
   logic [31:0]            reg_addr [12];

   always #2 clk = ~clk;

   apb_periph_top dut0 (
      .clk_i(clk), .rst_i(rst), .apb_req_i(req), .apb_rsp_o(apb_rsp),
      .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_oe_o(gpio_oe), .pwm_o(pwm),
      .cluster_o(cluster), .gwt_cfg_i(gwt_in), .gwt_cfg_ie_i(gwt_ie), .gwt_cfg_o(gwt_out)
   );

   apb_periph_checker chk0 (.clk_i(clk));

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Expected {pslverr, prdata} of a read
   function automatic logic [32:0] model_read(input logic [31:0] a);
      logic [11:0] ofs;
      logic [31:0] d;
      ofs = a[11:0];
      d   = '0;
      case (a[13:12])
         2'd0: d = (ofs == 12'h0) ? m_dir : (ofs == 12'h4) ? m_out : (ofs == 12'h8) ? m_in : '0;
         2'd1: begin
            if (ofs == 12'h0) d = {31'd0, m_en};
            if (ofs == 12'h4) d = {16'd0, m_period};
            if (ofs >= 12'h8 && ofs <= 12'h14 && ofs[1:0] == 2'd0) begin
               d = {16'd0, m_duty[ofs[3:2] - 2'd2]};
            end
         end
         2'd2: d = (ofs == 12'h0) ? {29'd0, m_cluster} : (ofs == 12'h4) ? m_gwt : '0;
         default: return {1'b1, 32'd0};
      endcase
      return {1'b0, d};
   endfunction

   task automatic model_write(input logic [31:0] a, input logic [31:0] d);
      logic [11:0] ofs;
      ofs = a[11:0];
      if (a[13:12] == 2'd0 && ofs == 12'h0) m_dir <= d;
      if (a[13:12] == 2'd0 && ofs == 12'h4) m_out <= d;
      if (a[13:12] == 2'd1 && ofs == 12'h0) m_en <= d[0];
      if (a[13:12] == 2'd1 && ofs == 12'h4) m_period <= d[15:0];
      if (a[13:12] == 2'd1 && ofs >= 12'h8 && ofs <= 12'h14 && ofs[1:0] == 2'd0) begin
         m_duty[ofs[3:2] - 2'd2] <= d[15:0];
      end
      if (a[13:12] == 2'd2 && ofs == 12'h0) m_cluster <= d[2:0];
      if (a[13:12] == 2'd2 && ofs == 12'h4) m_gwt <= d;
   endtask

   // Setup and access phase with an optional external load in the access cycle
   task automatic apb_access(input logic [31:0] a, input logic [31:0] d, input logic wr,
                             input logic load, input logic [31:0] load_val);
      logic [32:0] exp;
      @(posedge clk);
      exp = model_read(a);
      req.paddr <= a;
      req.pwdata <= d;
      req.pwrite <= wr;
      req.psel <= 1'b1;
      req.penable <= 1'b0;
      exp_err <= exp[32];
      exp_rdata <= exp[31:0];
      @(posedge clk);
      req.penable <= 1'b1;
      in_access <= 1'b1;
      gwt_in <= load_val;
      gwt_ie <= load;
      do @(posedge clk); while (!apb_rsp.pready);
      req.psel <= 1'b0;
      req.penable <= 1'b0;
      in_access <= 1'b0;
      gwt_ie <= 1'b0;
      if (wr) model_write(a, d);
      if (load) m_gwt <= load_val;
   endtask

   task automatic apb_write(input logic [31:0] a, input logic [31:0] d);
      apb_access(a, d, 1'b1, 1'b0, '0);
   endtask

   task automatic apb_read(input logic [31:0] a);
      apb_access(a, '0, 1'b0, 1'b0, '0);
   endtask

   task automatic pwm_duty_test();
      int p;
      int d [4];
      int hi [4];
      p = int'(next_rand() % 32'd12) + 2;
      apb_write(32'h1004, 32'(p));
      for (int n = 0; n < 4; n++) begin
         d[n] = int'(next_rand() % 32'(p + 3));
         apb_write(32'h1008 + 32'(4 * n), 32'(d[n]));
      end
      apb_write(32'h1000, 32'd1);
      repeat (4) @(posedge clk);
      hi = '{0, 0, 0, 0};
      repeat ((p + 1) * (p + 1)) begin
         @(posedge clk);
         for (int n = 0; n < 4; n++) hi[n] += int'(pwm[n]);
      end
      for (int n = 0; n < 4; n++) begin
         chk0.compare("pwm_o high count", 32'((p + 1) * ((d[n] < p + 1) ? d[n] : p + 1)),
                      32'(hi[n]));
      end
      // Disabled timer keeps every channel low
      apb_write(32'h1000, 32'd0);
      repeat (2) @(posedge clk);
      repeat (20) begin
         @(posedge clk);
         chk0.compare("pwm_o disabled", 32'd0, 32'(pwm));
      end
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] gpio_val;
      rst = 1'b1;
      req = '0;
      gpio_in = '0;
      gwt_in = '0;
      gwt_ie = 1'b0;
      reg_addr = '{32'h0000, 32'h0004, 32'h0008, 32'h000C, 32'h1000, 32'h1004,
                   32'h1008, 32'h1014, 32'h1018, 32'h2000, 32'h2004, 32'h2008};
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      @(posedge clk);
      chk0.compare("pwm_o after reset", 32'd0, 32'(pwm));
      chk0.compare("gpio_oe_o after reset", 32'd0, gpio_oe);
      chk0.compare("cluster_o after reset", 32'd0, 32'(cluster));
      chk_on <= 1'b1;
      for (int i = 0; i < N_RAND_WR; i++) begin
         a = reg_addr[next_rand() % 32'd12];
         apb_write(a, next_rand());
         apb_read(a);
      end
      for (int i = 0; i < 3; i++) begin
         @(posedge clk);
         gpio_val = next_rand();
         gpio_in <= gpio_val;
         m_in <= gpio_val;
         repeat (3) @(posedge clk);
         apb_read(32'h0008);
      end
      apb_write(32'h3000, 32'h1234_5678);
      apb_read(32'h3004);
      for (int i = 0; i < N_PWM_CFG; i++) pwm_duty_test();
      apb_access(32'h2004, '0, 1'b0, 1'b1, next_rand());
      apb_access(32'h2004, next_rand(), 1'b1, 1'b1, next_rand());
      apb_read(32'h2004);
      apb_write(32'h2004, next_rand());
      apb_read(32'h2004);
      repeat (4) @(posedge clk);
      $display("Checks: %0d  Errors: %0d", chk0.checks, chk0.errors);
      if (chk0.errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      wait (chk0.timed_out);
      $display("Run timed out after %0d cycles", chk0.cycles);
      $display("Errors found");
      $finish;
   end

endmodule

// ==== verif/apb_periph_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker of the testbench that watches the DUT ports,
// compares them with the model and limits the run time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module apb_periph_checker
   import apb_periph_pkg::*;
(
   input  logic clk_i
);

   localparam int unsigned CYCLE_LIMIT = 6000;

   int unsigned checks    = 0;
   int unsigned errors    = 0;
   int unsigned cycles    = 0;
   logic        timed_out = 1'b0;

   task automatic compare(input string name, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
      checks++;
      if (act_val !== exp_val) begin
         errors++;
         $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
      end
   endtask

   // Read data and error flag on every completed access
   always @(posedge clk_i) begin
      if (tb_apb_periph.chk_on && tb_apb_periph.dut0.apb_rsp_o.pready) begin
         compare("pslverr", 32'(tb_apb_periph.exp_err),
                 32'(tb_apb_periph.dut0.apb_rsp_o.pslverr));
         if (!tb_apb_periph.dut0.apb_req_i.pwrite) begin
            compare("prdata", tb_apb_periph.exp_rdata, tb_apb_periph.dut0.apb_rsp_o.prdata);
         end
      end
   end

   // Register outputs follow the shadow model every cycle
   always @(posedge clk_i) begin
      if (tb_apb_periph.chk_on) begin
         // Ready only in the access cycle of a transfer
         compare("pready", 32'(tb_apb_periph.in_access),
                 32'(tb_apb_periph.dut0.apb_rsp_o.pready));
         compare("gpio_o", tb_apb_periph.m_out, tb_apb_periph.dut0.gpio_o);
         compare("gpio_oe_o", tb_apb_periph.m_dir, tb_apb_periph.dut0.gpio_oe_o);
         compare("cluster_o", 32'(tb_apb_periph.m_cluster),
                 32'(tb_apb_periph.dut0.cluster_o));
         compare("gwt_cfg_o", tb_apb_periph.m_gwt, tb_apb_periph.dut0.gwt_cfg_o);
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         timed_out <= 1'b1;
      end
   end

endmodule

// ==== design/apb_periph_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB peripheral subsystem: one slave port decoded to
// GPIO, PWM timer and SoC control slots
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module apb_periph_top
   import apb_periph_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  apb_req_t               apb_req_i,
   output apb_rsp_t               apb_rsp_o,
   input  logic [`NUM_GPIO-1:0]   gpio_i,
   output logic [`NUM_GPIO-1:0]   gpio_o,
   output logic [`NUM_GPIO-1:0]   gpio_oe_o,
   output logic [`PWM_CH-1:0]     pwm_o,
   output cluster_ctrl_t          cluster_o,
   input  logic [`APB_DATA_W-1:0] gwt_cfg_i,
   input  logic                   gwt_cfg_ie_i,
   output logic [`APB_DATA_W-1:0] gwt_cfg_o
);

   apb_req_t gpio_req;
   apb_req_t pwm_req;
   apb_req_t soc_req;
   apb_rsp_t gpio_rsp;
   apb_rsp_t pwm_rsp;
   apb_rsp_t soc_rsp;
   pwm_cfg_t pwm_cfg;

   apb_periph_decode i_decode (
      .clk_i      ( clk_i     ),
      .rst_i      ( rst_i     ),
      .req_i      ( apb_req_i ),
      .rsp_o      ( apb_rsp_o ),
      .gpio_req_o ( gpio_req  ),
      .pwm_req_o  ( pwm_req   ),
      .soc_req_o  ( soc_req   ),
      .gpio_rsp_i ( gpio_rsp  ),
      .pwm_rsp_i  ( pwm_rsp   ),
      .soc_rsp_i  ( soc_rsp   )
   );

   gpio_ctrl i_gpio (
      .clk_i     ( clk_i     ),
      .rst_i     ( rst_i     ),
      .req_i     ( gpio_req  ),
      .rsp_o     ( gpio_rsp  ),
      .gpio_i    ( gpio_i    ),
      .gpio_o    ( gpio_o    ),
      .gpio_oe_o ( gpio_oe_o )
   );

   pwm_regs i_pwm_regs (
      .clk_i ( clk_i   ),
      .rst_i ( rst_i   ),
      .req_i ( pwm_req ),
      .rsp_o ( pwm_rsp ),
      .cfg_o ( pwm_cfg )
   );

   pwm_gen i_pwm_gen (
      .clk_i ( clk_i   ),
      .rst_i ( rst_i   ),
      .cfg_i ( pwm_cfg ),
      .pwm_o ( pwm_o   )
   );

   soc_ctrl_regs i_soc_ctrl (
      .clk_i        ( clk_i        ),
      .rst_i        ( rst_i        ),
      .req_i        ( soc_req      ),
      .rsp_o        ( soc_rsp      ),
      .cluster_o    ( cluster_o    ),
      .gwt_cfg_i    ( gwt_cfg_i    ),
      .gwt_cfg_ie_i ( gwt_cfg_ie_i ),
      .gwt_cfg_o    ( gwt_cfg_o    )
   );

endmodule

// ==== design/soc_ctrl_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC control slave: cluster fetch enable, boot mode and
// reset, plus a config word with an external load port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module soc_ctrl_regs
   import apb_periph_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  apb_req_t               req_i,
   output apb_rsp_t               rsp_o,
   output cluster_ctrl_t          cluster_o,
   input  logic [`APB_DATA_W-1:0] gwt_cfg_i,
   input  logic                   gwt_cfg_ie_i,
   output logic [`APB_DATA_W-1:0] gwt_cfg_o
);

   logic [`SLOT_LSB-1:0]   ofs;
   logic                   wr_en;
   cluster_ctrl_t          cluster_q;
   logic [`APB_DATA_W-1:0] gwt_q;
   logic [`APB_DATA_W-1:0] rdata;

   assign ofs   = req_i.paddr[`SLOT_LSB-1:0];
   assign wr_en = req_i.psel && req_i.penable && req_i.pwrite;

   // Cleared cluster_rstn keeps the cluster in reset
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cluster_q <= '0;
      end else if (wr_en && ofs == `SOC_CLUSTER_OFS) begin
         cluster_q <= req_i.pwdata[$bits(cluster_ctrl_t)-1:0];
      end
   end

   // External load wins over a bus write in the same cycle
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         gwt_q <= '0;
      end else if (gwt_cfg_ie_i) begin
         gwt_q <= gwt_cfg_i;
      end else if (wr_en && ofs == `SOC_GWT_CFG_OFS) begin
         gwt_q <= req_i.pwdata;
      end
   end

   always_comb begin
      rdata = '0;
      case (ofs)
         `SOC_CLUSTER_OFS: rdata[$bits(cluster_ctrl_t)-1:0] = cluster_q;
         `SOC_GWT_CFG_OFS: rdata = gwt_q;
         default:          rdata = '0;
      endcase
   end

   assign rsp_o.prdata  = (req_i.psel && !req_i.pwrite) ? rdata : '0;
   assign rsp_o.pready  = req_i.psel && req_i.penable;
   assign rsp_o.pslverr = 1'b0;

   assign cluster_o = cluster_q;
   assign gwt_cfg_o = gwt_q;

endmodule

// ==== design/pwm_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PWM period counter with a registered duty compare per
// channel, driven by the configuration from pwm_regs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module pwm_gen
   import apb_periph_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_i,
   input  pwm_cfg_t           cfg_i,
   output logic [`PWM_CH-1:0] pwm_o
);

   logic [`PWM_CNT_W-1:0] cnt_q;
   logic [`PWM_CH-1:0]    pwm_q;

   // Counts 0..period, held at zero while disabled
   always_ff @(posedge clk_i) begin
      if (rst_i || !cfg_i.en) begin
         cnt_q <= '0;
      end else if (cnt_q >= cfg_i.period) begin
         cnt_q <= '0;
      end else begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pwm_q <= '0;
      end else begin
         for (int n = 0; n < `PWM_CH; n++) begin
            pwm_q[n] <= cfg_i.en && (cnt_q < cfg_i.duty[n]);
         end
      end
   end

   assign pwm_o = pwm_q;

   // A shorter period only takes hold at the next wrap check
   a_cnt_in_period: assert property (@(posedge clk_i) disable iff (rst_i)
      cfg_i.en && $past(cfg_i.en) && ($past(cfg_i.period) == cfg_i.period)
      |-> cnt_q <= cfg_i.period);

endmodule

// ==== design/pwm_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PWM register block: enable, period and one duty per
// channel, written and read back over APB
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module pwm_regs
   import apb_periph_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  apb_req_t req_i,
   output apb_rsp_t rsp_o,
   output pwm_cfg_t cfg_o
);

   localparam int unsigned OFS_W = `SLOT_LSB;

   logic [OFS_W-1:0]       ofs;
   logic                   wr_en;
   pwm_cfg_t               cfg_q;
   logic [`APB_DATA_W-1:0] rdata;

   assign ofs   = req_i.paddr[OFS_W-1:0];
   assign wr_en = req_i.psel && req_i.penable && req_i.pwrite;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cfg_q <= '0;
      end else if (wr_en) begin
         case (ofs)
            `PWM_CTRL_OFS:   cfg_q.en <= req_i.pwdata[0];
            `PWM_PERIOD_OFS: cfg_q.period <= req_i.pwdata[`PWM_CNT_W-1:0];
            default: begin
               // Duty registers are one word apart from DUTY0
               for (int i = 0; i < `PWM_CH; i++) begin
                  if (ofs == `PWM_DUTY0_OFS + OFS_W'(4 * i)) begin
                     cfg_q.duty[i] <= req_i.pwdata[`PWM_CNT_W-1:0];
                  end
               end
            end
         endcase
      end
   end

   always_comb begin
      rdata = '0;
      case (ofs)
         `PWM_CTRL_OFS:   rdata[0] = cfg_q.en;
         `PWM_PERIOD_OFS: rdata[`PWM_CNT_W-1:0] = cfg_q.period;
         default: begin
            for (int i = 0; i < `PWM_CH; i++) begin
               if (ofs == `PWM_DUTY0_OFS + OFS_W'(4 * i)) begin
                  rdata[`PWM_CNT_W-1:0] = cfg_q.duty[i];
               end
            end
         end
      endcase
   end

   assign rsp_o.prdata  = (req_i.psel && !req_i.pwrite) ? rdata : '0;
   assign rsp_o.pready  = req_i.psel && req_i.penable;
   assign rsp_o.pslverr = 1'b0;

   assign cfg_o = cfg_q;

endmodule

// ==== design/gpio_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO slave with DIR and OUT registers and a two flop
// synchronizer feeding the read-only IN register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module gpio_ctrl
   import apb_periph_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  apb_req_t             req_i,
   output apb_rsp_t             rsp_o,
   input  logic [`NUM_GPIO-1:0] gpio_i,
   output logic [`NUM_GPIO-1:0] gpio_o,
   output logic [`NUM_GPIO-1:0] gpio_oe_o
);

   logic [`SLOT_LSB-1:0]       ofs;
   logic                       wr_en;
   logic [`NUM_GPIO-1:0]       dir_q;
   logic [`NUM_GPIO-1:0]       out_q;
   logic [1:0][`NUM_GPIO-1:0] sync_q;
   logic [`APB_DATA_W-1:0]     rdata;

   assign ofs   = req_i.paddr[`SLOT_LSB-1:0];
   assign wr_en = req_i.psel && req_i.penable && req_i.pwrite;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dir_q  <= '0;
         out_q  <= '0;
         sync_q <= '0;
      end else begin
         sync_q[0] <= gpio_i;
         sync_q[1] <= sync_q[0];
         if (wr_en && ofs == `GPIO_DIR_OFS) begin
            dir_q <= req_i.pwdata;
         end
         if (wr_en && ofs == `GPIO_OUT_OFS) begin
            out_q <= req_i.pwdata;
         end
      end
   end

   always_comb begin
      case (ofs)
         `GPIO_DIR_OFS: rdata = dir_q;
         `GPIO_OUT_OFS: rdata = out_q;
         `GPIO_IN_OFS:  rdata = sync_q[1];
         default:       rdata = '0;
      endcase
   end

   assign rsp_o.prdata  = (req_i.psel && !req_i.pwrite) ? rdata : '0;
   assign rsp_o.pready  = req_i.psel && req_i.penable;
   assign rsp_o.pslverr = 1'b0;

   assign gpio_o    = out_q;
   assign gpio_oe_o = dir_q;

   a_oe_known: assert property (@(posedge clk_i) disable iff (rst_i)
      !$isunknown(gpio_oe_o));

endmodule

// ==== design/apb_periph_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fans the APB slave port out to the peripheral slots.
// Slot 3 is unmapped and answered here with an error
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

module apb_periph_decode
   import apb_periph_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_i,
   input  apb_req_t req_i,
   output apb_rsp_t rsp_o,
   output apb_req_t gpio_req_o,
   output apb_req_t pwm_req_o,
   output apb_req_t soc_req_o,
   input  apb_rsp_t gpio_rsp_i,
   input  apb_rsp_t pwm_rsp_i,
   input  apb_rsp_t soc_rsp_i
);

   logic [`SLOT_W-1:0] slot;
   logic               err_sel;

   assign slot    = req_i.paddr[`SLOT_LSB +: `SLOT_W];
   assign err_sel = req_i.psel && (slot != `SLOT_GPIO) && (slot != `SLOT_PWM)
                    && (slot != `SLOT_SOC);

   // Same request to every slot, only the addressed one sees psel
   always_comb begin
      gpio_req_o      = req_i;
      pwm_req_o       = req_i;
      soc_req_o       = req_i;
      gpio_req_o.psel = req_i.psel && (slot == `SLOT_GPIO);
      pwm_req_o.psel  = req_i.psel && (slot == `SLOT_PWM);
      soc_req_o.psel  = req_i.psel && (slot == `SLOT_SOC);
   end

   always_comb begin
      case (slot)
         `SLOT_GPIO: rsp_o = gpio_rsp_i;
         `SLOT_PWM:  rsp_o = pwm_rsp_i;
         `SLOT_SOC:  rsp_o = soc_rsp_i;
         default: begin
            rsp_o.prdata  = '0;
            rsp_o.pready  = err_sel && req_i.penable;
            rsp_o.pslverr = err_sel && req_i.penable;
         end
      endcase
   end

   // Access phase must follow a setup phase
   a_setup_before_access: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i.psel && req_i.penable |-> $past(req_i.psel && !req_i.penable));

   a_one_slot: assert property (@(posedge clk_i) disable iff (rst_i)
      req_i.psel |-> $onehot({gpio_req_o.psel, pwm_req_o.psel, soc_req_o.psel, err_sel}));

endmodule

// ==== design/apb_periph_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus and configuration types shared by the decoder,
// the peripherals and the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "apb_periph_settings.svh"

package apb_periph_pkg;

   // One APB request as driven by the master
   typedef struct packed {
      logic [`APB_ADDR_W-1:0] paddr;
      logic [`APB_DATA_W-1:0] pwdata;
      logic                   pwrite;
      logic                   psel;
      logic                   penable;
   } apb_req_t;

   // Slave answer, zero wait states everywhere
   typedef struct packed {
      logic [`APB_DATA_W-1:0] prdata;
      logic                   pready;
      logic                   pslverr;
   } apb_rsp_t;

   // PWM configuration from the register block to the generator
   typedef struct packed {
      logic                                en;
      logic [`PWM_CNT_W-1:0]               period;
      logic [`PWM_CH-1:0][`PWM_CNT_W-1:0] duty;
   } pwm_cfg_t;

   // Cluster control, fetch_en is bit 0 of the CLUSTER register
   typedef struct packed {
      logic cluster_rstn;
      logic en_sa_boot;
      logic fetch_en;
   } cluster_ctrl_t;

endpackage

// ==== include/apb_periph_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, channel counts and the address map of the APB
// peripheral subsystem. Include wherever a macro is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef APB_PERIPH_SETTINGS_SVH
`define APB_PERIPH_SETTINGS_SVH

`define APB_ADDR_W 32
`define APB_DATA_W 32
`define NUM_GPIO 32
`define PWM_CH 4
`define PWM_CNT_W 16

// 4 KiB slots, slot index sits at bit SLOT_LSB
`define SLOT_LSB 12
`define SLOT_W 2
`define SLOT_GPIO 2'd0
`define SLOT_PWM 2'd1
`define SLOT_SOC 2'd2

// Register offsets within a slot
`define GPIO_DIR_OFS 12'h000
`define GPIO_OUT_OFS 12'h004
`define GPIO_IN_OFS 12'h008
`define PWM_CTRL_OFS 12'h000
`define PWM_PERIOD_OFS 12'h004
`define PWM_DUTY0_OFS 12'h008
`define SOC_CLUSTER_OFS 12'h000
`define SOC_GWT_CFG_OFS 12'h004

`endif
